/* Bender.yml */
package:
  name: fir_filter

sources:
  - src/fir_pkg.sv
  - src/axil_ctrl.sv
  - src/fir_engine.sv
  - src/axis_out_buf.sv
  - src/fir_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/bram_model.sv
      - verification/fir_tb.sv

/* src.f */
+incdir+verification
src/fir_pkg.sv
src/axil_ctrl.sv
src/fir_engine.sv
src/axis_out_buf.sv
src/fir_top.sv
verification/bram_model.sv
verification/fir_tb.sv

/* src/axil_ctrl.sv */
//------------------------------------------------------------
// axi-lite slave with tap access and the ap control register
// one transaction at a time, a read wins over a write
// tap addresses beyond the last tap are ignored and read zero
// awvalid/wvalid and arvalid must hold until their ready
//------------------------------------------------------------
`timescale 1ns/1ps

module axil_ctrl (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  fir_pkg::addr_t    awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  fir_pkg::data_t    wdata,
    input  logic              wvalid,
    output logic              wready,
    input  fir_pkg::addr_t    araddr,
    input  logic              arvalid,
    output logic              arready,
    output fir_pkg::data_t    rdata,
    output logic              rvalid,
    input  logic              rready,
    input  fir_pkg::data_t    tap_rdata,
    input  logic              run_done,
    output fir_pkg::tap_cfg_t tap_cfg,
    output logic              ap_start
);
    import fir_pkg::*;

    typedef enum logic [2:0] {
        L_IDLE,
        L_WACK,
        L_WUPD,
        L_RACK,
        L_RREQ,
        L_RDATA
    } lite_state_e;

    lite_state_e state;
    addr_t addr_q;
    data_t wdata_q;
    data_t rdata_q;
    data_t ctrl_word;
    logic rd_first;
    logic ap_done;
    logic ap_idle;
    logic hit_tap;
    logic hit_ctrl;

    // decode of the latched address
    assign hit_tap = (addr_q >= TAP_BASE) && (addr_q < TAP_BASE + addr_t'(4 * NUM_TAPS));
    assign hit_ctrl = (addr_q == REG_AP_CTRL);

    always_comb begin
        ctrl_word = '0;
        ctrl_word[AP_START_BIT] = ap_start;
        ctrl_word[AP_DONE_BIT] = ap_done;
        ctrl_word[AP_IDLE_BIT] = ap_idle;
    end

    // handshake outputs straight from the phase
    assign awready = (state == L_WACK);
    assign wready = (state == L_WACK);
    assign arready = (state == L_RACK);
    assign rvalid = (state == L_RDATA);

    // tap data arrives one cycle after the ram read
    assign rdata = (rd_first && hit_tap) ? tap_rdata : rdata_q;

    assign tap_cfg.wr = (state == L_WUPD) && hit_tap;
    assign tap_cfg.rd = (state == L_RREQ) && hit_tap;
    assign tap_cfg.idx = tap_idx_t'((addr_q - TAP_BASE) >> 2);
    assign tap_cfg.wdata = wdata_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= L_IDLE;
            rd_first <= 1'b0;
        end else begin
            rd_first <= (state == L_RREQ);
            case (state)
                L_IDLE: begin
                    // reads first
                    if (arvalid) begin
                        state <= L_RACK;
                    end else if (awvalid && wvalid) begin
                        state <= L_WACK;
                    end
                end
                L_WACK:  state <= L_WUPD;
                L_WUPD:  state <= L_IDLE;
                L_RACK:  state <= L_RREQ;
                L_RREQ:  state <= L_RDATA;
                L_RDATA: begin
                    if (rready) begin
                        state <= L_IDLE;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // address and data capture on the handshake
    always_ff @(posedge axis_clk) begin
        if (state == L_WACK) begin
            addr_q <= awaddr;
            wdata_q <= wdata;
        end else if (state == L_RACK) begin
            addr_q <= araddr;
        end
        // snapshot so rdata stays put while rvalid waits
        if (state == L_RREQ) begin
            rdata_q <= hit_ctrl ? ctrl_word : '0;
        end else if (rd_first) begin
            rdata_q <= rdata;
        end
    end

    // ap bits, start is a single-cycle pulse
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done <= 1'b0;
            ap_idle <= 1'b1;
        end else begin
            ap_start <= 1'b0;
            if (run_done) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end else if (state == L_RREQ && hit_ctrl) begin
                // done is cleared once it has been read
                ap_done <= 1'b0;
            end
            if (state == L_WUPD && hit_ctrl && wdata_q[AP_START_BIT] && ap_idle) begin
                ap_start <= 1'b1;
                ap_idle <= 1'b0;
            end
        end
    end

endmodule

/* src/axis_out_buf.sv */
//------------------------------------------------------------
// single-entry holding register for the output stream
// data and last stay stable while sm_tready is low
//------------------------------------------------------------
`timescale 1ns/1ps

module axis_out_buf (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  fir_pkg::fir_result_t result,
    input  logic                 result_valid,
    output logic                 result_ready,
    output fir_pkg::data_t       sm_tdata,
    output logic                 sm_tvalid,
    output logic                 sm_tlast,
    input  logic                 sm_tready
);
    import fir_pkg::*;

    fir_result_t hold_q;
    logic full;
    logic load;

    // room when empty or draining this cycle
    assign result_ready = !full || sm_tready;
    assign load = result_valid && result_ready;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (sm_tready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (load) begin
            hold_q <= result;
        end
    end

    assign sm_tvalid = full;
    assign sm_tdata = hold_q.data;
    assign sm_tlast = hold_q.last;

endmodule

/* src/fir_engine.sv */
//------------------------------------------------------------
// fir run sequencer, one multiplier and one adder
// one output per sample, NUM_TAPS + 2 cycles after the input
// tap ram is open to the register port only while idle
// both rams must have a one-cycle read latency
//------------------------------------------------------------
`timescale 1ns/1ps

module fir_engine (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  logic                 ap_start,
    input  fir_pkg::tap_cfg_t    tap_cfg,
    input  fir_pkg::data_t       ss_tdata,
    input  logic                 ss_tvalid,
    input  logic                 ss_tlast,
    output logic                 ss_tready,
    input  fir_pkg::data_t       tap_Do,
    input  fir_pkg::data_t       data_Do,
    output fir_pkg::data_t       tap_rdata,
    output logic                 run_done,
    output fir_pkg::ram_req_t    tap_ram,
    output fir_pkg::ram_req_t    data_ram,
    output fir_pkg::fir_result_t result,
    output logic                 result_valid,
    input  logic                 result_ready
);
    import fir_pkg::*;

    run_state_e state;
    // op counter, newest slot, samples of this run so far
    tap_idx_t cnt;
    tap_idx_t ptr;
    tap_idx_t fill;
    tap_idx_t hist_idx;
    logic accept;
    logic mac_en;
    logic term_ok;
    logic last_q;
    data_t acc;
    data_t term;

    function automatic addr_t word_addr(tap_idx_t idx);
        return addr_t'(idx) << 2;
    endfunction

    assign ss_tready = (state == WAIT_IN);
    assign accept = ss_tready && ss_tvalid;

    // slot of x[n-cnt], wrapped modulo NUM_TAPS
    assign hist_idx = (ptr >= cnt) ? ptr - cnt : ptr + tap_idx_t'(NUM_TAPS) - cnt;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= IDLE;
            cnt <= '0;
            ptr <= '0;
            fill <= '0;
            mac_en <= 1'b0;
            term_ok <= 1'b0;
            last_q <= 1'b0;
        end else begin
            // read data returns one cycle after the request
            mac_en <= (state == MAC);
            term_ok <= (cnt < fill);
            case (state)
                IDLE: begin
                    if (ap_start) begin
                        state <= WAIT_IN;
                        fill <= '0;
                    end
                end
                WAIT_IN: begin
                    if (accept) begin
                        state <= MAC;
                        cnt <= '0;
                        last_q <= ss_tlast;
                        // saturates once the history is full
                        if (fill != tap_idx_t'(NUM_TAPS)) begin
                            fill <= fill + 1'b1;
                        end
                    end
                end
                MAC: begin
                    if (cnt == tap_idx_t'(NUM_TAPS - 1)) begin
                        state <= DRAIN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DRAIN: state <= HOLD_OUT;
                HOLD_OUT: begin
                    if (result_ready) begin
                        ptr <= (ptr == tap_idx_t'(NUM_TAPS - 1)) ? '0 : ptr + 1'b1;
                        state <= last_q ? IDLE : WAIT_IN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // history older than the run counts as zero
    assign term = term_ok ? data_Do : '0;

    // partial sum, restarted on every new sample
    always_ff @(posedge axis_clk) begin
        if (accept) begin
            acc <= '0;
        end else if (mac_en) begin
            acc <= acc + tap_Do * term;
        end
    end

    always_comb begin
        tap_ram = '0;
        data_ram = '0;
        if (state == IDLE) begin
            // register port owns the tap ram
            tap_ram.we = {4{tap_cfg.wr}};
            tap_ram.en = tap_cfg.wr | tap_cfg.rd;
            tap_ram.addr = word_addr(tap_cfg.idx);
            tap_ram.di = tap_cfg.wdata;
        end else if (state == MAC) begin
            tap_ram.en = 1'b1;
            tap_ram.addr = word_addr(cnt);
            data_ram.en = 1'b1;
            data_ram.addr = word_addr(hist_idx);
        end
        // new sample goes into the newest slot
        if (accept) begin
            data_ram.we = 4'hf;
            data_ram.en = 1'b1;
            data_ram.addr = word_addr(ptr);
            data_ram.di = ss_tdata;
        end
    end

    assign tap_rdata = tap_Do;
    assign result.data = acc;
    assign result.last = last_q;
    assign result_valid = (state == HOLD_OUT);
    assign run_done = result_valid && result_ready && last_q;

endmodule

/* src/fir_pkg.sv */
//------------------------------------------------------------
// shared types, register map and tap count of the fir
// data is signed 32-bit, products and sums truncate to 32 bits
// tap i sits at TAP_BASE + 4i on the bus and at 4i in its ram
//------------------------------------------------------------
package fir_pkg;

    // sample, tap and result word
    typedef logic signed [31:0] data_t;
    // byte address, shared by axi-lite and both rams
    typedef logic [11:0] addr_t;
    // tap number or history slot
    typedef logic [3:0] tap_idx_t;

    localparam int NUM_TAPS = 11;

    // register map
    localparam addr_t REG_AP_CTRL = 12'h000;
    localparam addr_t TAP_BASE = 12'h020;

    // bits of the ap control register
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT = 1;
    localparam int AP_IDLE_BIT = 2;

    // one request to a single-port bram
    typedef struct packed {
        logic [3:0] we;
        logic en;
        addr_t addr;
        data_t di;
    } ram_req_t;

    // tap access from the register port
    typedef struct packed {
        logic wr;
        logic rd;
        tap_idx_t idx;
        data_t wdata;
    } tap_cfg_t;

    // one filter output on its way to the stream
    typedef struct packed {
        data_t data;
        logic last;
    } fir_result_t;

    // run sequencing of the engine
    typedef enum logic [2:0] {
        IDLE,
        WAIT_IN,
        MAC,
        DRAIN,
        HOLD_OUT
    } run_state_e;

endpackage

/* src/fir_top.sv */
//------------------------------------------------------------
// 11-tap fir with axi-lite config and axi-stream data
// taps and history live in two external single-port brams
// with one-cycle read latency
//------------------------------------------------------------
`timescale 1ns/1ps

module fir_top (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  fir_pkg::addr_t awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  fir_pkg::data_t wdata,
    input  logic           wvalid,
    output logic           wready,
    input  fir_pkg::addr_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output fir_pkg::data_t rdata,
    output logic           rvalid,
    input  logic           rready,
    input  fir_pkg::data_t ss_tdata,
    input  logic           ss_tvalid,
    input  logic           ss_tlast,
    output logic           ss_tready,
    output fir_pkg::data_t sm_tdata,
    output logic           sm_tvalid,
    output logic           sm_tlast,
    input  logic           sm_tready,
    output logic [3:0]     tap_WE,
    output logic           tap_EN,
    output fir_pkg::data_t tap_Di,
    output fir_pkg::addr_t tap_A,
    input  fir_pkg::data_t tap_Do,
    output logic [3:0]     data_WE,
    output logic           data_EN,
    output fir_pkg::data_t data_Di,
    output fir_pkg::addr_t data_A,
    input  fir_pkg::data_t data_Do
);
    import fir_pkg::*;

    tap_cfg_t tap_cfg;
    logic ap_start;
    data_t tap_rdata;
    logic run_done;
    ram_req_t tap_ram;
    ram_req_t data_ram;
    fir_result_t result;
    logic result_valid;
    logic result_ready;

    axil_ctrl u_axil_ctrl (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .tap_rdata  (tap_rdata),
        .run_done   (run_done),
        .tap_cfg    (tap_cfg),
        .ap_start   (ap_start)
    );

    fir_engine u_fir_engine (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .ap_start     (ap_start),
        .tap_cfg      (tap_cfg),
        .ss_tdata     (ss_tdata),
        .ss_tvalid    (ss_tvalid),
        .ss_tlast     (ss_tlast),
        .ss_tready    (ss_tready),
        .tap_Do       (tap_Do),
        .data_Do      (data_Do),
        .tap_rdata    (tap_rdata),
        .run_done     (run_done),
        .tap_ram      (tap_ram),
        .data_ram     (data_ram),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    axis_out_buf u_axis_out_buf (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .sm_tdata     (sm_tdata),
        .sm_tvalid    (sm_tvalid),
        .sm_tlast     (sm_tlast),
        .sm_tready    (sm_tready)
    );

    // bram pins from the request structs
    assign tap_WE = tap_ram.we;
    assign tap_EN = tap_ram.en;
    assign tap_A = tap_ram.addr;
    assign tap_Di = tap_ram.di;
    assign data_WE = data_ram.we;
    assign data_EN = data_ram.en;
    assign data_A = data_ram.addr;
    assign data_Di = data_ram.di;

endmodule

/* verification/bram_model.sv */
//------------------------------------------------------------
// single-port ram, one-cycle read latency, byte write enables
// 1024 words addressed by byte, a read returns the old word
// power-up contents follow the address, so stale reads show
//------------------------------------------------------------
`timescale 1ns/1ps

module bram_model (
    input  logic           clk,
    input  logic [3:0]     we,
    input  logic           en,
    input  fir_pkg::addr_t addr,
    input  fir_pkg::data_t di,
    output fir_pkg::data_t dout
);
    import fir_pkg::*;

    logic [31:0] mem [0:1023];
    logic [9:0] widx;

    // word index from the byte address
    assign widx = addr[11:2];

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i << 2);
        end
    end

    always @(posedge clk) begin
        if (en) begin
            dout <= mem[widx];
            // each lane written on its own enable
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[widx][8*b +: 8] <= di[8*b +: 8];
                end
            end
        end
    end

endmodule

/* verification/fir_tb_tasks.svh */
//------------------------------------------------------------
// lfsr source, axi-lite bus tasks and the fir reference model
// included inside fir_tb, uses its signals, taps and samples
// bus tasks give up after WAIT_LIMIT cycles and count an error
//------------------------------------------------------------
`ifndef FIR_TB_TASKS_SVH
`define FIR_TB_TASKS_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11
logic [15:0] lfsr_q;

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        r = {r[30:0], fb};
    end
    return r;
endfunction

// signed 8-bit value, sign extended
function automatic data_t rand_data();
    logic [31:0] b;
    b = rand_bits(8);
    return {{24{b[7]}}, b[7:0]};
endfunction

// y[n] = sum of tap[k] * x[n-k], x before the run is zero
function automatic data_t fir_model(input int n);
    data_t acc;
    acc = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
        if (n - k >= 0) begin
            acc = acc + taps[k] * samples[n - k];
        end
    end
    return acc;
endfunction

task automatic report_mismatch(input string name, input data_t exp, input data_t act);
    $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    errors++;
endtask

task automatic axil_write(input addr_t addr, input data_t data);
    bit ok;
    @(posedge axis_clk);
    awaddr <= addr;
    awvalid <= 1'b1;
    wdata <= data;
    wvalid <= 1'b1;
    ok = 1'b0;
    for (int c = 0; c < WAIT_LIMIT && !ok; c++) begin
        @(posedge axis_clk);
        ok = awready && wready;
    end
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    if (!ok) begin
        $display("write to 0x%03h was never accepted", addr);
        errors++;
    end
endtask

task automatic axil_read(input addr_t addr, output data_t data);
    bit ok;
    data = '0;
    @(posedge axis_clk);
    araddr <= addr;
    arvalid <= 1'b1;
    ok = 1'b0;
    for (int c = 0; c < WAIT_LIMIT && !ok; c++) begin
        @(posedge axis_clk);
        ok = arready;
    end
    arvalid <= 1'b0;
    rready <= 1'b1;
    if (!ok) begin
        $display("read address 0x%03h was never accepted", addr);
        errors++;
    end
    ok = 1'b0;
    for (int c = 0; c < WAIT_LIMIT && !ok; c++) begin
        @(posedge axis_clk);
        ok = rvalid;
    end
    // rdata taken on the rvalid/rready edge
    if (ok) begin
        data = rdata;
    end else begin
        $display("no read data came back from 0x%03h", addr);
        errors++;
    end
    rready <= 1'b0;
endtask

`endif

/* verification/fir_tb.sv */
//------------------------------------------------------------
// testbench for fir_top with two behavioral brams
// random taps, samples, input gaps and output stalls
// expected outputs come from a direct convolution model
//------------------------------------------------------------
`timescale 1ns/1ps

module fir_tb;
    import fir_pkg::*;

    localparam int MAX_SAMPLES = 64;
    localparam int RDY_LEN = 256;
    localparam int WAIT_LIMIT = 200;

    logic axis_clk;
    logic axis_rst_n;
    addr_t awaddr;
    logic awvalid;
    logic awready;
    data_t wdata;
    logic wvalid;
    logic wready;
    addr_t araddr;
    logic arvalid;
    logic arready;
    data_t rdata;
    logic rvalid;
    logic rready;
    data_t ss_tdata;
    logic ss_tvalid;
    logic ss_tlast;
    logic ss_tready;
    data_t sm_tdata;
    logic sm_tvalid;
    logic sm_tlast;
    logic sm_tready;
    logic [3:0] tap_WE;
    logic tap_EN;
    data_t tap_Di;
    addr_t tap_A;
    data_t tap_Do;
    logic [3:0] data_WE;
    logic data_EN;
    data_t data_Di;
    addr_t data_A;
    data_t data_Do;

    // stimulus and expected values of the current run
    data_t taps [NUM_TAPS];
    data_t samples [MAX_SAMPLES];
    data_t exp_out [MAX_SAMPLES];
    int gaps [MAX_SAMPLES];
    bit rdy_pat [RDY_LEN];
    int errors;
    int tests;
    int failed_tests;

    `include "fir_tb_tasks.svh"

    fir_top dut (.*);

    bram_model u_tap_bram (
        .clk  (axis_clk),
        .we   (tap_WE),
        .en   (tap_EN),
        .addr (tap_A),
        .di   (tap_Di),
        .dout (tap_Do)
    );

    bram_model u_data_bram (
        .clk  (axis_clk),
        .we   (data_WE),
        .en   (data_EN),
        .addr (data_A),
        .di   (data_Di),
        .dout (data_Do)
    );

    always #4 axis_clk = ~axis_clk;

    task automatic end_test(input string name, input int mark);
        tests++;
        if (errors != mark) begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - mark);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic drive_samples(input int n);
        bit ok;
        for (int i = 0; i < n; i++) begin
            repeat (gaps[i]) @(posedge axis_clk);
            @(posedge axis_clk);
            ss_tdata <= samples[i];
            ss_tvalid <= 1'b1;
            ss_tlast <= (i == n - 1);
            ok = 1'b0;
            for (int c = 0; c < WAIT_LIMIT && !ok; c++) begin
                @(posedge axis_clk);
                ok = ss_tready;
            end
            ss_tvalid <= 1'b0;
            ss_tlast <= 1'b0;
            if (!ok) begin
                $display("sample %0d was never accepted on the input stream", i);
                errors++;
            end
        end
    endtask

    task automatic collect_outputs(input string name, input int n);
        int got;
        int idle;
        int cyc;
        bit held;
        data_t held_data;
        got = 0;
        idle = 0;
        cyc = 0;
        held = 1'b0;
        held_data = '0;
        sm_tready <= rdy_pat[0];
        while (got < n && idle < WAIT_LIMIT) begin
            @(posedge axis_clk);
            // stalled beat must come back unchanged
            if (held && sm_tdata !== held_data) begin
                report_mismatch({name, " hold"}, held_data, sm_tdata);
            end
            if (held && !sm_tvalid) begin
                $display("%s: sm_tvalid dropped before the beat was taken", name);
                errors++;
            end
            held = sm_tvalid && !sm_tready;
            held_data = sm_tdata;
            if (sm_tvalid && sm_tready) begin
                if (sm_tdata !== exp_out[got]) begin
                    report_mismatch(name, exp_out[got], sm_tdata);
                end
                if (sm_tlast !== (got == n - 1)) begin
                    report_mismatch({name, " tlast"}, data_t'(got == n - 1), data_t'(sm_tlast));
                end
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            cyc++;
            sm_tready <= rdy_pat[cyc % RDY_LEN];
        end
        sm_tready <= 1'b1;
        if (got < n) begin
            $display("%s: only %0d of %0d outputs arrived", name, got, n);
            errors++;
        end
        // nothing more may follow the last beat
        for (int c = 0; c < 20; c++) begin
            @(posedge axis_clk);
            if (sm_tvalid) begin
                $display("%s: output seen beyond the expected %0d", name, n);
                errors++;
            end
        end
    endtask

    task automatic run_stream(input string name, input int n, input bit with_bp);
        for (int i = 0; i < n; i++) begin
            samples[i] = rand_data();
            gaps[i] = with_bp ? int'(rand_bits(4)) : 0;
        end
        // ready mostly low so a full buffer stalls the engine
        for (int i = 0; i < RDY_LEN; i++) begin
            rdy_pat[i] = with_bp ? (rand_bits(4) == 0) : 1'b1;
        end
        for (int i = 0; i < n; i++) begin
            exp_out[i] = fir_model(i);
        end
        axil_write(REG_AP_CTRL, data_t'(1 << AP_START_BIT));
        fork
            drive_samples(n);
            collect_outputs(name, n);
        join
    endtask

    // polls until done and idle are both set
    task automatic poll_done(input string name);
        data_t rd;
        int tries;
        rd = '0;
        tries = 0;
        while (!(rd[AP_DONE_BIT] && rd[AP_IDLE_BIT]) && tries < 50) begin
            axil_read(REG_AP_CTRL, rd);
            tries++;
        end
        if (!(rd[AP_DONE_BIT] && rd[AP_IDLE_BIT])) begin
            $display("%s: ap_done and ap_idle never came up", name);
            errors++;
        end
    endtask

    initial begin
        data_t rd;
        int mark;
        axis_clk = 1'b0;
        axis_rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        ss_tdata = '0;
        ss_tvalid = 1'b0;
        ss_tlast = 1'b0;
        sm_tready = 1'b0;
        lfsr_q = 16'd33;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        repeat (5) @(posedge axis_clk);
        axis_rst_n <= 1'b1;
        repeat (2) @(posedge axis_clk);

        mark = errors;
        axil_read(REG_AP_CTRL, rd);
        if (rd !== data_t'(1 << AP_IDLE_BIT)) begin
            report_mismatch("reset_ctrl", data_t'(1 << AP_IDLE_BIT), rd);
        end
        end_test("reset_ctrl", mark);

        mark = errors;
        for (int i = 0; i < NUM_TAPS; i++) begin
            taps[i] = rand_data();
            axil_write(TAP_BASE + addr_t'(4 * i), taps[i]);
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            axil_read(TAP_BASE + addr_t'(4 * i), rd);
            if (rd !== taps[i]) begin
                report_mismatch("tap_readback", taps[i], rd);
            end
        end
        end_test("tap_readback", mark);

        mark = errors;
        run_stream("stream_basic", 24, 1'b0);
        // also clears ap_done before the next run
        poll_done("stream_basic");
        end_test("stream_basic", mark);

        mark = errors;
        run_stream("stream_backpressure", 24, 1'b1);
        end_test("stream_backpressure", mark);

        mark = errors;
        poll_done("done_flags");
        axil_read(REG_AP_CTRL, rd);
        if (rd !== data_t'(1 << AP_IDLE_BIT)) begin
            report_mismatch("done_flags", data_t'(1 << AP_IDLE_BIT), rd);
        end
        end_test("done_flags", mark);

        // old history in the data ram must not leak in
        mark = errors;
        for (int i = 0; i < NUM_TAPS; i++) begin
            taps[i] = rand_data();
            axil_write(TAP_BASE + addr_t'(4 * i), taps[i]);
        end
        run_stream("fresh_history", 15, 1'b0);
        end_test("fresh_history", mark);

        $display("summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
